// ==== bench/uart_checker.sv ====
`timescale 1ns/1ps

module uart_checker (
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            i_tx_enable,
	input  logic [uart_pkg::DATA_WIDTH-1:0] i_tx_data,
	input  logic                            i_tx_busy,
	input  logic                            i_serial_out,
	input  logic                            i_rx_valid,
	input  uart_pkg::rx_result_t            i_rx_result,
	input  logic                            i_flip_parity,
	input  logic                            i_flip_stop,
	input  logic                            i_test_end,
	input  logic [3:0]                      i_test_num,
	input  logic                            i_report,
	output int                              o_pending,
	output int                              o_errors
);
	import uart_pkg::*;

	localparam int FRAME_CYCLES = FRAME_BITS * CLOCKS_PER_BIT;
	localparam int MID_SAMPLE   = CLOCKS_PER_BIT / 2 + 1;   // edges into a bit

	rx_result_t            exp_q[$];
	rx_result_t            want;
	logic [DATA_WIDTH-1:0] shape_word;
	logic                  shape_active;
	logic                  accept_seen;
	int                    shape_count;
	int                    error_count;
	int                    test_start_errors;
	int                    tests_passed;
	int                    tests_failed;
	int                    words_sent;
	int                    words_received;

	// what the receiver must report for a word and the line fault applied to it
	function automatic rx_result_t expected_result(input logic [DATA_WIDTH-1:0] word,
			input logic flip_parity, input logic flip_stop);
		rx_result_t r;
		r.data       = word;
		r.parity_err = flip_parity;
		r.frame_err  = flip_stop;
		return r;
	endfunction

	// line level of frame bit k for a word
	function automatic logic frame_bit(input logic [DATA_WIDTH-1:0] word, input int k);
		logic even;
		even = 1'b0;
		for (int i = 0; i < DATA_WIDTH; i++) begin
			even = even ^ word[i];
		end
		if (k == 0) begin
			return 1'b0;
		end else if (k <= DATA_WIDTH) begin
			return word[k-1];   // lsb first
		end else if (k == DATA_WIDTH + 1) begin
			return even;
		end
		return 1'b1;
	endfunction

	function automatic string test_name(input logic [3:0] num);
		case (num)
			4'd1: return "reset state";
			4'd2: return "loopback of random words";
			4'd3: return "frame shape";
			4'd4: return "back-pressure";
			4'd5: return "parity fault";
			4'd6: return "stop fault and recovery";
			default: return "unknown";
		endcase
	endfunction

	task automatic report_error(input string msg);
		$display("error at %0t: %s", $time, msg);
		error_count++;
	endtask

	always @(posedge clk) begin
		if (reset) begin
			shape_active = 1'b0;
			accept_seen  = 1'b0;
		end else begin
			if (!accept_seen && (i_tx_busy || !i_serial_out)) begin
				report_error("transmitter not idle before the first request");
			end

			if (shape_active) begin
				shape_count++;
				if (shape_count % CLOCKS_PER_BIT == MID_SAMPLE && shape_count < FRAME_CYCLES) begin
					if (i_serial_out !== frame_bit(shape_word, shape_count / CLOCKS_PER_BIT)) begin
						report_error($sformatf("word %h frame bit %0d is %b on the line",
							shape_word, shape_count / CLOCKS_PER_BIT, i_serial_out));
					end
				end
				if (shape_count == FRAME_CYCLES && !i_tx_busy) begin
					report_error("busy fell before the end of the stop bit");
				end
				if (shape_count == FRAME_CYCLES + 1) begin
					if (i_tx_busy) begin
						report_error("busy still high after the stop bit");
					end
					shape_active = 1'b0;
				end
			end

			if (i_tx_enable && !i_tx_busy) begin   // accepted on this edge
				exp_q.push_back(expected_result(i_tx_data, i_flip_parity, i_flip_stop));
				shape_word   = i_tx_data;
				shape_count  = 0;
				shape_active = 1'b1;
				accept_seen  = 1'b1;
				words_sent++;
			end

			if (i_rx_valid) begin
				words_received++;
				if (exp_q.size() == 0) begin
					$display("extra valid at %0t: a result arrived with no word outstanding", $time);
					error_count++;
				end else begin
					want = exp_q.pop_front();
					if (i_rx_result !== want) begin
						report_error($sformatf("got data %h pe %b fe %b, expected data %h pe %b fe %b",
							i_rx_result.data, i_rx_result.parity_err, i_rx_result.frame_err,
							want.data, want.parity_err, want.frame_err));
					end
				end
			end

			if (i_test_end) begin
				if (error_count == test_start_errors) begin
					tests_passed++;
					$display("test %0d %s: pass", i_test_num, test_name(i_test_num));
				end else begin
					tests_failed++;
					$display("test %0d %s: fail, %0d errors", i_test_num, test_name(i_test_num),
						error_count - test_start_errors);
				end
				test_start_errors = error_count;
			end

			if (i_report) begin
				if (exp_q.size() != 0) begin
					$display("missing valid: %0d sent words never came back", exp_q.size());
					error_count++;
				end
				$display("tests %0d passed %0d failed, words %0d sent %0d received, errors %0d",
					tests_passed, tests_failed, words_sent, words_received, error_count);
			end
		end
		o_pending <= exp_q.size();
		o_errors  <= error_count;
	end

endmodule

// ==== bench/uart_sva.sv ====
`timescale 1ns/1ps

module uart_sva (
	input logic clk,
	input logic reset,
	input logic i_tx_enable,
	input logic i_tx_busy,
	input logic i_serial_out,
	input logic i_rx_valid
);
	import uart_pkg::*;

	localparam int FRAME_CYCLES = FRAME_BITS * CLOCKS_PER_BIT;

	int busy_run;   // consecutive cycles with busy high
	int fail_count = 0;   // assertion failures so far

	always_ff @(posedge clk) begin
		if (reset) begin
			busy_run <= 0;
		end else if (i_tx_busy) begin
			busy_run <= busy_run + 1;
		end else begin
			busy_run <= 0;
		end
	end

	idle_after_reset: assert property (@(posedge clk) $fell(reset) |-> !i_tx_busy && i_serial_out)
		else begin
			fail_count++;
			$error("transmitter not idle after reset");
		end

	busy_after_accept: assert property (@(posedge clk) disable iff (reset)
		i_tx_enable && !i_tx_busy |=> i_tx_busy)
		else begin
			fail_count++;
			$error("busy did not rise after an accepted request");
		end

	busy_length: assert property (@(posedge clk) disable iff (reset)
		$fell(i_tx_busy) |-> busy_run == FRAME_CYCLES)
		else begin
			fail_count++;
			$error("busy was not high for one full frame");
		end

	valid_single: assert property (@(posedge clk) disable iff (reset)
		i_rx_valid |=> !i_rx_valid)
		else begin
			fail_count++;
			$error("receive valid held for more than one cycle");
		end

endmodule

// ==== bench/uart_tb.sv ====
`timescale 1ns/1ps

module uart_tb;
	import uart_pkg::*;

	localparam int CLK_PERIOD  = 40;
	localparam int LOOP_WORDS  = 6;
	localparam int NUM_FRAMES  = LOOP_WORDS + 4 + 2 + 1 + 2;   // frames over all tests
	localparam int WD_MARGIN   = 4;
	localparam int WATCHDOG_NS = (NUM_FRAMES + WD_MARGIN) * 100 * CLK_PERIOD;

	logic                  clk;
	logic                  reset;
	logic                  tx_enable;
	logic [DATA_WIDTH-1:0] tx_data;
	logic                  tx_busy;
	logic                  serial_out;
	logic                  serial_in;
	logic                  rx_valid;
	rx_result_t            rx_result;
	logic                  line_flip;   // inverts the loopback line
	logic                  flip_parity;
	logic                  flip_stop;
	logic                  test_end;
	logic [3:0]            test_num;
	logic                  report_req;
	int                    pending;
	int                    errors;
	integer                seed;

	uart_top uut (
		.clk          (clk),
		.reset        (reset),
		.i_tx_enable  (tx_enable),
		.i_tx_data    (tx_data),
		.o_tx_busy    (tx_busy),
		.o_serial_out (serial_out),
		.i_serial_in  (serial_in),
		.o_rx_valid   (rx_valid),
		.o_rx_result  (rx_result)
	);

	uart_checker u_checker (
		.clk           (clk),
		.reset         (reset),
		.i_tx_enable   (tx_enable),
		.i_tx_data     (tx_data),
		.i_tx_busy     (tx_busy),
		.i_serial_out  (serial_out),
		.i_rx_valid    (rx_valid),
		.i_rx_result   (rx_result),
		.i_flip_parity (flip_parity),
		.i_flip_stop   (flip_stop),
		.i_test_end    (test_end),
		.i_test_num    (test_num),
		.i_report      (report_req),
		.o_pending     (pending),
		.o_errors      (errors)
	);

	bind uart_top uart_sva u_sva (
		.clk          (clk),
		.reset        (reset),
		.i_tx_enable  (i_tx_enable),
		.i_tx_busy    (o_tx_busy),
		.i_serial_out (o_serial_out),
		.i_rx_valid   (o_rx_valid)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// loopback with optional inversion
	always @(posedge clk) begin
		serial_in <= serial_out ^ line_flip;
	end

	// holds the request until the transmitter takes it, then corrupts one bit if asked
	task automatic send_word(input logic [DATA_WIDTH-1:0] word, input logic inject_parity,
			input logic inject_stop);
		int bit_index;
		tx_enable   <= 1'b1;
		tx_data     <= word;
		flip_parity <= inject_parity;
		flip_stop   <= inject_stop;
		@(posedge clk);
		while (tx_busy) @(posedge clk);
		tx_enable   <= 1'b0;
		tx_data     <= DATA_WIDTH'($random(seed));   // data is free after acceptance
		flip_parity <= 1'b0;
		flip_stop   <= 1'b0;
		if (inject_parity || inject_stop) begin
			bit_index = inject_parity ? DATA_WIDTH + 1 : FRAME_BITS - 1;
			repeat (bit_index * CLOCKS_PER_BIT) @(posedge clk);
			line_flip <= 1'b1;
			repeat (CLOCKS_PER_BIT) @(posedge clk);
			line_flip <= 1'b0;
		end
	endtask

	task automatic wait_frames_done();
		@(posedge clk);
		while (pending != 0) @(posedge clk);
	endtask

	task automatic finish_test(input int num);
		wait_frames_done();
		repeat (4) @(posedge clk);
		test_num <= 4'(num);
		test_end <= 1'b1;
		@(posedge clk);
		test_end <= 1'b0;
	endtask

	initial begin
		seed        = 32'h284a;
		reset       = 1'b1;
		tx_enable   = 1'b0;
		tx_data     = '0;
		serial_in   = 1'b1;
		line_flip   = 1'b0;
		flip_parity = 1'b0;
		flip_stop   = 1'b0;
		test_end    = 1'b0;
		test_num    = '0;
		report_req  = 1'b0;
		repeat (4) @(posedge clk);
		reset <= 1'b0;

		repeat (20) @(posedge clk);   // idle line watched by the checker
		finish_test(1);

		for (int i = 0; i < LOOP_WORDS; i++) begin
			send_word(DATA_WIDTH'($random(seed)), 1'b0, 1'b0);   // back to back
		end
		finish_test(2);

		send_word(8'h00, 1'b0, 1'b0);
		send_word(8'hff, 1'b0, 1'b0);
		send_word(8'h01, 1'b0, 1'b0);
		send_word(8'h96, 1'b0, 1'b0);
		finish_test(3);

		send_word(DATA_WIDTH'($random(seed)), 1'b0, 1'b0);
		repeat (20) begin   // requests while busy, all dropped
			tx_enable <= 1'b1;
			tx_data   <= DATA_WIDTH'($random(seed));
			@(posedge clk);
		end
		tx_enable <= 1'b0;
		send_word(DATA_WIDTH'($random(seed)), 1'b0, 1'b0);
		finish_test(4);

		send_word(DATA_WIDTH'($random(seed)), 1'b1, 1'b0);
		finish_test(5);

		send_word(DATA_WIDTH'($random(seed)), 1'b0, 1'b1);
		wait_frames_done();
		repeat (CLOCKS_PER_BIT) @(posedge clk);
		send_word(DATA_WIDTH'($random(seed)), 1'b0, 1'b0);
		finish_test(6);

		report_req <= 1'b1;
		@(posedge clk);
		report_req <= 1'b0;
		repeat (2) @(posedge clk);
		if (errors == 0 && uut.u_sva.fail_count == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

// ==== hw/uart_pkg.sv ====
package uart_pkg;

	localparam int DATA_WIDTH     = 8;
	localparam int CLOCKS_PER_BIT = 8;
	localparam int SAMPLE_POINT   = CLOCKS_PER_BIT / 2;   // mid-bit sampling
	localparam int SYNC_STAGES    = 3;
	localparam int FRAME_BITS     = DATA_WIDTH + 3;       // start, data, parity, stop
	localparam bit PARITY_ODD     = 1'b0;                 // even parity

	// counter widths derived from the sizes above
	localparam int TIMER_WIDTH = $clog2(CLOCKS_PER_BIT);
	localparam int INDEX_WIDTH = $clog2(DATA_WIDTH);

	typedef enum logic [2:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_PARITY,
		TX_STOP
	} tx_state_e;

	typedef enum logic [2:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_PARITY,
		RX_STOP
	} rx_state_e;

	typedef struct packed {
		logic [DATA_WIDTH-1:0] data;
		logic                  parity_err;   // parity sample mismatch
		logic                  frame_err;    // stop sample was low
	} rx_result_t;

	// parity bit as sent on the line
	function automatic logic parity_of(input logic [DATA_WIDTH-1:0] data);
		return (^data) ^ PARITY_ODD;
	endfunction

endpackage

// ==== hw/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 i_serial,
	output logic                 o_valid,
	output uart_pkg::rx_result_t o_result
);
	import uart_pkg::*;

	// synchronizer and edge detect
	logic [SYNC_STAGES-1:0] sync_q;
	logic                   line;
	logic                   line_prev;
	logic                   line_fall;

	// sampler
	rx_state_e              state;
	logic [TIMER_WIDTH-1:0] bit_timer;
	logic [INDEX_WIDTH-1:0] data_index;
	logic [DATA_WIDTH-1:0]  data_q;
	logic                   parity_q;
	logic                   stop_q;
	logic                   frame_done;
	logic                   start_tick;
	logic                   bit_tick;

	assign line      = sync_q[SYNC_STAGES-1];
	assign line_fall = line_prev && !line;

	// start bit is checked half a bit in, the rest a full bit apart
	assign start_tick = (bit_timer == TIMER_WIDTH'(SAMPLE_POINT - 1));
	assign bit_tick   = (bit_timer == TIMER_WIDTH'(CLOCKS_PER_BIT - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			sync_q    <= '1;   // idle line level
			line_prev <= 1'b1;
		end else begin
			sync_q    <= {sync_q[SYNC_STAGES-2:0], i_serial};
			line_prev <= line;
		end
	end

	// sampled payload
	always_ff @(posedge clk) begin
		if (state == RX_DATA && bit_tick) begin
			data_q <= {line, data_q[DATA_WIDTH-1:1]};   // lsb arrives first
		end
		if (state == RX_PARITY && bit_tick) begin
			parity_q <= line;
		end
		if (state == RX_STOP && bit_tick) begin
			stop_q <= line;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state      <= RX_IDLE;
			bit_timer  <= '0;
			data_index <= '0;
			frame_done <= 1'b0;
		end else begin
			frame_done <= 1'b0;
			case (state)
				RX_IDLE: begin
					if (line_fall) begin
						state     <= RX_START;
						bit_timer <= '0;
					end
				end

				RX_START: begin
					bit_timer <= bit_timer + 1'b1;
					if (start_tick) begin
						bit_timer  <= '0;
						data_index <= '0;
						if (line) begin
							state <= RX_IDLE;   // glitch, not a start bit
						end else begin
							state <= RX_DATA;
						end
					end
				end

				RX_DATA: begin
					bit_timer <= bit_timer + 1'b1;
					if (bit_tick) begin
						bit_timer  <= '0;
						data_index <= data_index + 1'b1;
						if (data_index == INDEX_WIDTH'(DATA_WIDTH - 1)) begin
							state <= RX_PARITY;
						end
					end
				end

				RX_PARITY: begin
					bit_timer <= bit_timer + 1'b1;
					if (bit_tick) begin
						state     <= RX_STOP;
						bit_timer <= '0;
					end
				end

				RX_STOP: begin
					bit_timer <= bit_timer + 1'b1;
					if (bit_tick) begin
						state      <= RX_IDLE;   // free for the next start edge
						bit_timer  <= '0;
						frame_done <= 1'b1;
					end
				end

				default: begin
					state <= RX_IDLE;
				end
			endcase
		end
	end

	// frame check stage, data is passed on even with a flag set
	always_ff @(posedge clk) begin
		if (frame_done) begin
			o_result.data       <= data_q;
			o_result.parity_err <= (parity_q != parity_of(data_q));
			o_result.frame_err  <= !stop_q;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			o_valid <= 1'b0;
		end else begin
			o_valid <= frame_done;   // one pulse per frame
		end
	end

endmodule

// ==== hw/uart_top.sv ====
`timescale 1ns/1ps

module uart_top (
	input  logic                            clk,
	input  logic                            reset,

	// transmit side
	input  logic                            i_tx_enable,
	input  logic [uart_pkg::DATA_WIDTH-1:0] i_tx_data,
	output logic                            o_tx_busy,
	output logic                            o_serial_out,

	// receive side
	input  logic                            i_serial_in,   // async to clk
	output logic                            o_rx_valid,
	output uart_pkg::rx_result_t            o_rx_result
);
	import uart_pkg::*;

	logic [DATA_WIDTH-1:0] tx_data;
	logic                  tx_busy;
	logic                  tx_serial;
	logic                  rx_valid;
	rx_result_t            rx_result;

	assign tx_data      = i_tx_data;
	assign o_tx_busy    = tx_busy;
	assign o_serial_out = tx_serial;
	assign o_rx_valid   = rx_valid;
	assign o_rx_result  = rx_result;

	uart_tx u_tx (
		.clk      (clk),
		.reset    (reset),
		.i_enable (i_tx_enable),
		.i_data   (tx_data),
		.o_busy   (tx_busy),
		.o_serial (tx_serial)
	);

	uart_rx u_rx (
		.clk      (clk),
		.reset    (reset),
		.i_serial (i_serial_in),
		.o_valid  (rx_valid),
		.o_result (rx_result)
	);

endmodule

// ==== hw/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx (
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            i_enable,
	input  logic [uart_pkg::DATA_WIDTH-1:0] i_data,
	output logic                            o_busy,
	output logic                            o_serial
);
	import uart_pkg::*;

	tx_state_e              state;
	logic [FRAME_BITS-2:0]  shift_q;     // bits queued behind the one on the line
	logic [TIMER_WIDTH-1:0] bit_timer;
	logic [INDEX_WIDTH-1:0] data_index;
	logic [FRAME_BITS-1:0]  frame;
	logic                   accept;
	logic                   bit_done;

	// stop, parity, data lsb first, start
	assign frame = {1'b1, parity_of(i_data), i_data, 1'b0};

	assign accept   = i_enable && !o_busy;
	assign bit_done = (bit_timer == TIMER_WIDTH'(CLOCKS_PER_BIT - 1));

	// frame payload, loaded on acceptance and shifted once per bit
	always_ff @(posedge clk) begin
		if (accept) begin
			shift_q <= frame[FRAME_BITS-1:1];
		end else if (o_busy && bit_done) begin
			shift_q <= {1'b1, shift_q[FRAME_BITS-2:1]};   // back-fill with idle level
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state      <= TX_IDLE;
			o_busy     <= 1'b0;
			o_serial   <= 1'b1;   // line idles high
			bit_timer  <= '0;
			data_index <= '0;
		end else begin
			case (state)
				TX_IDLE: begin
					if (accept) begin
						state     <= TX_START;
						o_busy    <= 1'b1;
						o_serial  <= frame[0];   // start bit on the next cycle
						bit_timer <= '0;
					end
				end

				TX_START: begin
					bit_timer <= bit_timer + 1'b1;
					if (bit_done) begin
						state      <= TX_DATA;
						o_serial   <= shift_q[0];
						bit_timer  <= '0;
						data_index <= '0;
					end
				end

				TX_DATA: begin
					bit_timer <= bit_timer + 1'b1;
					if (bit_done) begin
						o_serial   <= shift_q[0];
						bit_timer  <= '0;
						data_index <= data_index + 1'b1;
						if (data_index == INDEX_WIDTH'(DATA_WIDTH - 1)) begin
							state <= TX_PARITY;   // last data bit done
						end
					end
				end

				TX_PARITY: begin
					bit_timer <= bit_timer + 1'b1;
					if (bit_done) begin
						state     <= TX_STOP;
						o_serial  <= shift_q[0];   // stop bit
						bit_timer <= '0;
					end
				end

				TX_STOP: begin
					bit_timer <= bit_timer + 1'b1;
					if (bit_done) begin
						state     <= TX_IDLE;
						o_busy    <= 1'b0;   // ready again after the full stop bit
						o_serial  <= 1'b1;
						bit_timer <= '0;
					end
				end

				default: begin
					state    <= TX_IDLE;
					o_busy   <= 1'b0;
					o_serial <= 1'b1;
				end
			endcase
		end
	end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Builds the UART testbench with Verilator and runs it.
# The exit status is 0 only if the run prints the pass message.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module uart_tb -o uart_sim

output=$(./obj_dir/uart_sim)
echo "$output"

if echo "$output" | grep -q "ALL CHECKS PASSED"; then
	echo "simulation passed"
	exit 0
fi

echo "simulation failed"
exit 1

// ==== verilog.f ====
hw/uart_pkg.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart_top.sv
bench/uart_sva.sv
bench/uart_checker.sv
bench/uart_tb.sv
